/* Makefile */
# Verilator simulation of the SSR receive path

VERILATOR       ?= verilator
TOP             ?= tb_ssr_rx
FILE_LIST       ?= list.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
PASS_MSG        ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/sr_chain_pkg.sv */
//**************************************************
// ssr receive chain widths, field layout and frame struct
//**************************************************
`default_nettype none

package sr_chain_pkg;

  // field widths of the received ssr chain
  localparam int SSR_PCS_W = 81;
  localparam int SSR_RSV_W = 5;
  localparam int SSR_PAR_W = 6;

  // data part is the pcs field with the reserved field above it
  localparam int SSR_DATA_W = SSR_PCS_W + SSR_RSV_W;

  // full chain, parity bits sit on top of the data
  localparam int SSR_FRAME_W = SSR_DATA_W + SSR_PAR_W;

  // pcs status bits from the aib side
  typedef logic [SSR_PCS_W-1:0] ssr_pcs_t;

  // reserved bits
  typedef logic [SSR_RSV_W-1:0] ssr_rsv_t;

  // one even parity bit per data group
  typedef logic [SSR_PAR_W-1:0] ssr_par_t;

  // frame layout, msb first
  // bit 0 of pcs is the first bit on the wire
  typedef struct packed {
    ssr_par_t par;
    ssr_rsv_t rsv;
    ssr_pcs_t pcs;
  } ssr_frame_t;

endpackage

`default_nettype wire

/* common/sr_check_pkg.sv */
//**************************************************
// ssr parity group layout and error flag type
//**************************************************
`default_nettype none

package sr_check_pkg;

  import sr_chain_pkg::*;

  // width of each full parity group
  localparam int PAR_GRP_W = 16;

  // full groups covering the low data bits
  localparam int PAR_FULL_GRPS = SSR_DATA_W / PAR_GRP_W;

  // short group at the top of the data part
  localparam int PAR_LAST_W = SSR_DATA_W - PAR_FULL_GRPS * PAR_GRP_W;

  // one error flag per parity group, bit k for group k
  typedef logic [SSR_PAR_W-1:0] par_err_t;

endpackage

`default_nettype wire

/* hdl/ssr_rx_top.sv */
//**************************************************
// ssr receive top, deserializer, frame latch and checker
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module ssr_rx_top
  import sr_chain_pkg::*;
  import sr_check_pkg::*;
(
  input  wire        sr_clock_rx_osc_clk,
  input  wire        sr_reset_rx_osc_clk_rst_n,
  // aib side
  input  wire        aib_fabric_ssr_data_in,
  input  wire        aib_fabric_ssr_load_in,
  // static config
  input  wire        r_sr_parity_en,
  // fabric side
  output ssr_frame_t ssr_frame,
  output wire        rx_async_hssi_fabric_ssr_load,
  output par_err_t   sr_parity_error_flag
);

  ssr_frame_t chain;
  wire        frame_strobe;

  ssr_deserializer u_deserializer (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .ssr_data_in               (aib_fabric_ssr_data_in),
    .ssr_load                  (aib_fabric_ssr_load_in),
    .chain                     (chain)
  );

  ssr_frame_latch u_frame_latch (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .ssr_load                  (aib_fabric_ssr_load_in),
    .chain                     (chain),
    .frame                     (ssr_frame),
    .load_gated                (rx_async_hssi_fabric_ssr_load),
    .frame_strobe              (frame_strobe)
  );

  // checks the latched frame, not the moving chain
  ssr_parity_checker u_parity_checker (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .frame                     (ssr_frame),
    .frame_strobe              (frame_strobe),
    .r_sr_parity_en            (r_sr_parity_en),
    .parity_error              (sr_parity_error_flag)
  );

endmodule

`default_nettype wire

/* list.f */
common/sr_chain_pkg.sv
common/sr_check_pkg.sv
ssr_rx/ssr_deserializer.sv
ssr_rx/ssr_frame_latch.sv
ssr_rx/ssr_parity_checker.sv
hdl/ssr_rx_top.sv
testbench/tb_ssr_rx.sv

/* ssr_rx/ssr_deserializer.sv */
//**************************************************
// ssr serial to parallel shift chain
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module ssr_deserializer
  import sr_chain_pkg::*;
(
  input  wire        sr_clock_rx_osc_clk,
  input  wire        sr_reset_rx_osc_clk_rst_n,
  input  wire        ssr_data_in,
  input  wire        ssr_load,
  output ssr_frame_t chain
);

  logic [SSR_FRAME_W-1:0] shift_next;

  // new bit enters at the msb and walks down
  // after a full frame the first wire bit sits in bit 0
  assign shift_next = {ssr_data_in, chain[SSR_FRAME_W-1:1]};

  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      chain <= '0;
    end
    else if (!ssr_load)
    begin
      chain <= ssr_frame_t'(shift_next);
    end
    // hold during the load cycle
  end

endmodule

`default_nettype wire

/* ssr_rx/ssr_frame_latch.sv */
//**************************************************
// ssr frame latch, first load gating and frame strobe
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module ssr_frame_latch
  import sr_chain_pkg::*;
(
  input  wire        sr_clock_rx_osc_clk,
  input  wire        sr_reset_rx_osc_clk_rst_n,
  input  wire        ssr_load,
  input  ssr_frame_t chain,
  output ssr_frame_t frame,
  output logic       load_gated,
  output logic       frame_strobe
);

  logic load_dly;
  logic gate_open;

  // capture on every raw load so the fabric sees the latest frame
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      frame <= '0;
    end
    else if (ssr_load)
    begin
      frame <= chain;
    end
  end

  // delayed load for falling edge detect
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      load_dly <= 1'b0;
    end
    else
    begin
      load_dly <= ssr_load;
    end
  end

  // sticky, opens once the first load has fallen
  // the first pulse may carry a partial chain
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      gate_open <= 1'b0;
    end
    else if (!gate_open)
    begin
      gate_open <= load_dly && !ssr_load;
    end
  end

  assign load_gated = ssr_load & gate_open;

  // frame holds the new data while the strobe is high
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      frame_strobe <= 1'b0;
    end
    else
    begin
      frame_strobe <= load_gated;
    end
  end

endmodule

`default_nettype wire

/* ssr_rx/ssr_parity_checker.sv */
//**************************************************
// ssr check qualifier, group parity checks, masked flags
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module ssr_parity_checker
  import sr_chain_pkg::*;
  import sr_check_pkg::*;
(
  input  wire        sr_clock_rx_osc_clk,
  input  wire        sr_reset_rx_osc_clk_rst_n,
  input  ssr_frame_t frame,
  input  wire        frame_strobe,
  input  wire        r_sr_parity_en,
  output par_err_t   parity_error
);

  logic [SSR_DATA_W-1:0] data;
  logic                  qualifier_dly0;
  logic                  qualifier;
  par_err_t              mismatch;
  par_err_t              error_q;

  assign data = {frame.rsv, frame.pcs};

  // first strobe after the gate opens, kept as a sticky level
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      qualifier_dly0 <= 1'b0;
    end
    else if (!qualifier_dly0)
    begin
      qualifier_dly0 <= frame_strobe;
    end
  end

  // armed on the second strobe
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      qualifier <= 1'b0;
    end
    else if (!qualifier)
    begin
      qualifier <= frame_strobe && qualifier_dly0;
    end
  end

  // even parity per group against the received parity bit
  always_comb
  begin
    for (int k = 0; k < PAR_FULL_GRPS; k++)
    begin
      mismatch[k] = (^data[k*PAR_GRP_W +: PAR_GRP_W]) ^ frame.par[k];
    end
    // short group at the top
    mismatch[SSR_PAR_W-1] = (^data[SSR_DATA_W-1 -: PAR_LAST_W]) ^ frame.par[SSR_PAR_W-1];
  end

  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!sr_reset_rx_osc_clk_rst_n)
    begin
      error_q <= '0;
    end
    else if (frame_strobe && qualifier)
    begin
      error_q <= mismatch;
    end
  end

  assign parity_error = error_q & {SSR_PAR_W{r_sr_parity_en}};

endmodule

`default_nettype wire

/* testbench/tb_ssr_rx.sv */
//**************************************************
// ssr receive testbench, lcg frames, parity model and checks
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_ssr_rx
  import sr_chain_pkg::*;
  import sr_check_pkg::*;
();

  logic       sr_clock_rx_osc_clk = 1'b0;
  logic       sr_reset_rx_osc_clk_rst_n;
  logic       aib_fabric_ssr_data_in;
  logic       aib_fabric_ssr_load_in;
  logic       r_sr_parity_en;
  ssr_frame_t ssr_frame;
  logic       rx_async_hssi_fabric_ssr_load;
  par_err_t   sr_parity_error_flag;

  logic [31:0] rng_state = 32'd49;
  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          frames_sent = 0;
  string       test_name;
  // expected content of the registered error flags
  par_err_t    err_model = '0;

  always
  begin
    #4 sr_clock_rx_osc_clk = ~sr_clock_rx_osc_clk;
  end

  ssr_rx_top UUT (
    .sr_clock_rx_osc_clk           (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n     (sr_reset_rx_osc_clk_rst_n),
    .aib_fabric_ssr_data_in        (aib_fabric_ssr_data_in),
    .aib_fabric_ssr_load_in        (aib_fabric_ssr_load_in),
    .r_sr_parity_en                (r_sr_parity_en),
    .ssr_frame                     (ssr_frame),
    .rx_async_hssi_fabric_ssr_load (rx_async_hssi_fabric_ssr_load),
    .sr_parity_error_flag          (sr_parity_error_flag)
  );

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // even parity with data bit i in group i / 16
  function automatic ssr_par_t ref_parity(input logic [SSR_DATA_W-1:0] d);
    logic [SSR_DATA_W-1:0] shifted;
    ssr_par_t              p;
    int                    i;
    int                    grp;
    shifted = d;
    p = '0;
    for (i = 0; i < SSR_DATA_W; i++)
    begin
      grp = i / PAR_GRP_W;
      if (shifted[0])
      begin
        p = p ^ (ssr_par_t'(1) << grp);
      end
      shifted = shifted >> 1;
    end
    return p;
  endfunction

  function automatic ssr_frame_t make_frame(input logic corrupt, input int bit_k);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [95:0] raw;
    ssr_frame_t  f;
    r0 = lcg_next();
    r1 = lcg_next();
    r2 = lcg_next();
    raw = {r2, r1, r0};
    f.pcs = raw[SSR_PCS_W-1:0];
    f.rsv = raw[SSR_DATA_W-1:SSR_PCS_W];
    f.par = ref_parity(raw[SSR_DATA_W-1:0]);
    if (corrupt)
    begin
      f.par = f.par ^ (ssr_par_t'(1) << bit_k);
    end
    return f;
  endfunction

  task automatic check_frame(input ssr_frame_t exp);
    assert (ssr_frame === exp)
    else
    begin
      $display("Error: ssr_frame expected 0x%h got 0x%h", exp, ssr_frame);
      errors++;
    end
  endtask

  task automatic check_gated_load(input logic exp);
    assert (rx_async_hssi_fabric_ssr_load === exp)
    else
    begin
      $display("Error: rx_async_hssi_fabric_ssr_load expected 0x%h got 0x%h",
               exp, rx_async_hssi_fabric_ssr_load);
      errors++;
    end
  endtask

  task automatic check_error_flags(input par_err_t exp);
    assert (sr_parity_error_flag === exp)
    else
    begin
      $display("Error: sr_parity_error_flag expected 0x%h got 0x%h",
               exp, sr_parity_error_flag);
      errors++;
    end
  endtask

  // 92 shift cycles bit 0 first, one load cycle, then three idle bits
  task automatic send_frame(input ssr_frame_t f);
    logic [SSR_FRAME_W-1:0] bits;
    logic                   exp_gate;
    logic [31:0]            r;
    bits = f;
    // first pulse after reset is blocked
    exp_gate = (frames_sent != 0);
    for (int i = 0; i < SSR_FRAME_W; i++)
    begin
      @(negedge sr_clock_rx_osc_clk);
      aib_fabric_ssr_load_in = 1'b0;
      aib_fabric_ssr_data_in = bits[0];
      bits = bits >> 1;
    end
    @(negedge sr_clock_rx_osc_clk);
    aib_fabric_ssr_load_in = 1'b1;
    aib_fabric_ssr_data_in = 1'b0;
    #2;
    check_gated_load(exp_gate);
    frames_sent++;
    // one blocked pulse plus two arming strobes before flags follow frames
    if (frames_sent >= 4)
    begin
      err_model = ref_parity({f.rsv, f.pcs}) ^ f.par;
    end
    for (int i = 0; i < 3; i++)
    begin
      @(negedge sr_clock_rx_osc_clk);
      r = lcg_next();
      aib_fabric_ssr_load_in = 1'b0;
      aib_fabric_ssr_data_in = r[16];
      if (i == 0)
      begin
        check_frame(f);
      end
    end
    check_error_flags(r_sr_parity_en ? err_model : '0);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == errors_at_start)
    begin
      $display("test %0s: passed", test_name);
    end
    else
    begin
      tests_failed++;
      $display("test %0s: failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  initial
  begin
    int n;
    sr_reset_rx_osc_clk_rst_n = 1'b0;
    aib_fabric_ssr_data_in = 1'b0;
    aib_fabric_ssr_load_in = 1'b0;
    r_sr_parity_en = 1'b1;

    start_test("reset_state");
    repeat (4) @(negedge sr_clock_rx_osc_clk);
    // raw load while in reset meets a closed gate
    aib_fabric_ssr_load_in = 1'b1;
    #2;
    check_gated_load(1'b0);
    @(negedge sr_clock_rx_osc_clk);
    aib_fabric_ssr_load_in = 1'b0;
    sr_reset_rx_osc_clk_rst_n = 1'b1;
    check_frame('0);
    check_gated_load(1'b0);
    check_error_flags('0);
    finish_test();

    // both frames carry a flipped parity bit that must stay unflagged
    start_test("first_load_gating");
    send_frame(make_frame(1'b1, 0));
    send_frame(make_frame(1'b1, 3));
    finish_test();

    start_test("qualifier");
    for (n = 0; n < 3; n++)
    begin
      send_frame(make_frame(1'b0, 0));
    end
    finish_test();

    start_test("frame_capture");
    for (n = 0; n < 4; n++)
    begin
      send_frame(make_frame(1'b0, 0));
    end
    finish_test();

    // each flipped bit flags its group and the next good frame clears it
    start_test("error_detection");
    for (n = 0; n < SSR_PAR_W; n++)
    begin
      send_frame(make_frame(1'b1, n));
      send_frame(make_frame(1'b0, 0));
    end
    finish_test();

    start_test("masking");
    r_sr_parity_en = 1'b0;
    send_frame(make_frame(1'b1, 4));
    // the mask only gates the output so the stored flag shows again
    r_sr_parity_en = 1'b1;
    #2;
    check_error_flags(err_model);
    send_frame(make_frame(1'b0, 0));
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
